// ==== spsa_pkg.sv ====
package spsa_pkg;

	localparam int ADC_WIDTH = 12;
	localparam int DAC_WIDTH = 14;
	localparam int N_CHAN = 2;
	localparam int DAC_LATENCY_CYCLES = 7;
	localparam int ADC_LATENCY_CYCLES = 10;
	localparam int CNT_WIDTH = 5;
	localparam int DELTA_MAG = 64;
	localparam int GAIN_SHIFT = 4;
	localparam int DAC_MAX = 2 ** DAC_WIDTH - 1;
	localparam logic [DAC_WIDTH-1:0] U_INIT = 14'd8192;
	localparam logic [ADC_WIDTH-1:0] GAIN_INIT = 12'd4;

	localparam int STEP_WIDTH = 16;
	localparam int STEP_MAX = 2 ** (STEP_WIDTH - 1) - 1;
	localparam int STEP_MIN = -(2 ** (STEP_WIDTH - 1));
	localparam int ITER_WIDTH = 16;

	// x^16+x^14+x^13+x^11+1 in right-shifting Galois form.
	localparam int LFSR_WIDTH = 16;
	localparam logic [LFSR_WIDTH-1:0] LFSR_TAPS = 16'hB400;
	localparam logic [N_CHAN-1:0][LFSR_WIDTH-1:0] LFSR_SEED = {16'h5A3C, 16'hACE1};

	localparam int WB_ADR_WIDTH = 3;
	localparam int WB_DATA_WIDTH = 32;
	localparam logic [WB_ADR_WIDTH-1:0] REG_CTRL = 3'd0;
	localparam logic [WB_ADR_WIDTH-1:0] REG_GAIN = 3'd1;
	localparam logic [WB_ADR_WIDTH-1:0] REG_STATUS = 3'd2;
	localparam logic [WB_ADR_WIDTH-1:0] REG_ITER = 3'd3;
	localparam logic [WB_ADR_WIDTH-1:0] REG_U0 = 3'd4;
	localparam logic [WB_ADR_WIDTH-1:0] REG_U1 = 3'd5;

	typedef enum logic [2:0] {
		PH_IDLE,
		PH_PLUS,
		PH_SAMPLE_P,
		PH_MINUS,
		PH_SAMPLE_M,
		PH_UPDATE
	} phase_e;

	typedef enum logic [1:0] {
		SEL_HOLD,
		SEL_PLUS,
		SEL_MINUS
	} dac_sel_e;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [WB_ADR_WIDTH-1:0] adr;
		logic [WB_DATA_WIDTH-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		logic [WB_DATA_WIDTH-1:0] dat;
	} wb_rsp_t;

	typedef struct packed {
		logic update;
		logic signed [STEP_WIDTH-1:0] step;
	} chan_ctrl_t;

	typedef struct packed {
		logic [DAC_WIDTH-1:0] u;
		logic [DAC_WIDTH-1:0] u_plus;
		logic [DAC_WIDTH-1:0] u_minus;
	} chan_out_t;

endpackage

// ==== spsa_wb_regs.sv ====
module spsa_wb_regs (
	input logic adc_clk,
	input logic arst_n,
	input spsa_pkg::wb_req_t wb_req,
	output spsa_pkg::wb_rsp_t wb_rsp,
	output logic run,
	output logic [spsa_pkg::ADC_WIDTH-1:0] gain,
	input logic busy,
	input spsa_pkg::phase_e phase,
	input logic [spsa_pkg::ITER_WIDTH-1:0] iter,
	input logic [spsa_pkg::N_CHAN-1:0][spsa_pkg::DAC_WIDTH-1:0] u_rb
);
	import spsa_pkg::*;

	logic req;
	logic ack_q;
	logic [WB_DATA_WIDTH-1:0] dat_q;
	logic [WB_DATA_WIDTH-1:0] rd_data;

	// a request is served once; ack blocks a second hit on the next cycle.
	assign req = wb_req.cyc & wb_req.stb & ~ack_q;

	always_comb begin
		rd_data = '0;
		case (wb_req.adr)
			REG_CTRL: rd_data[0] = run;
			REG_GAIN: rd_data[ADC_WIDTH-1:0] = gain;
			REG_STATUS: rd_data[3:0] = {phase, busy};
			REG_ITER: rd_data[ITER_WIDTH-1:0] = iter;
			REG_U0: rd_data[DAC_WIDTH-1:0] = u_rb[0];
			REG_U1: rd_data[DAC_WIDTH-1:0] = u_rb[1];
			default: rd_data = '0; // unmapped reads return zero.
		endcase
	end

	always_ff @(posedge adc_clk or negedge arst_n) begin
		if (!arst_n) begin
			ack_q <= 1'b0;
			run <= 1'b0;
			gain <= GAIN_INIT;
		end else begin
			ack_q <= req;
			if (req && wb_req.we) begin
				case (wb_req.adr)
					REG_CTRL: run <= wb_req.dat[0];
					REG_GAIN: gain <= wb_req.dat[ADC_WIDTH-1:0];
					default: ; // status, count and setpoints are read only.
				endcase
			end
		end
	end

	always_ff @(posedge adc_clk) begin
		if (req) begin
			dat_q <= rd_data;
		end
	end

	assign wb_rsp.ack = ack_q;
	assign wb_rsp.dat = dat_q;

endmodule

// ==== trig_sync.sv ====
module trig_sync (
	input logic adc_clk,
	input logic arst_n,
	input logic trig_in,
	input logic run,
	output logic trig_pulse
);

	logic [1:0] sync_q;
	logic prev_q;

	// trig_in comes from outside the adc_clk domain.
	always_ff @(posedge adc_clk or negedge arst_n) begin
		if (!arst_n) begin
			sync_q <= 2'b00;
			prev_q <= 1'b0;
			trig_pulse <= 1'b0;
		end else begin
			sync_q <= {sync_q[0], trig_in};
			prev_q <= sync_q[1];
			trig_pulse <= run & sync_q[1] & ~prev_q; // one cycle per rising edge.
		end
	end

endmodule

// ==== perturb_rng.sv ====
module perturb_rng (
	input logic adc_clk,
	input logic arst_n,
	input logic advance,
	output logic [spsa_pkg::N_CHAN-1:0] sign
);
	import spsa_pkg::*;

	logic [N_CHAN-1:0][LFSR_WIDTH-1:0] state;

	// each channel has its own generator so the two signs are uncorrelated.
	always_ff @(posedge adc_clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= LFSR_SEED;
		end else if (advance) begin
			for (int i = 0; i < N_CHAN; i++) begin
				if (state[i][0]) begin
					state[i] <= (state[i] >> 1) ^ LFSR_TAPS;
				end else begin
					state[i] <= state[i] >> 1;
				end
			end
		end
	end

	always_comb begin
		for (int i = 0; i < N_CHAN; i++) begin
			sign[i] = state[i][0]; // 1 means the perturbation is negative.
		end
	end

endmodule

// ==== spsa_channel.sv ====
module spsa_channel (
	input logic adc_clk,
	input logic arst_n,
	input logic sign,
	input spsa_pkg::chan_ctrl_t ctrl,
	output spsa_pkg::chan_out_t out
);
	import spsa_pkg::*;

	localparam int EXT_WIDTH = STEP_WIDTH + 2;

	logic [DAC_WIDTH-1:0] u;
	logic signed [EXT_WIDTH-1:0] delta_ext;
	logic signed [EXT_WIDTH-1:0] pert;
	logic signed [EXT_WIDTH-1:0] step_ext;
	logic signed [EXT_WIDTH-1:0] step_dir;

	// adds a signed offset to a DAC code and clamps to the converter range.
	function automatic logic [DAC_WIDTH-1:0] sat_add(
		input logic [DAC_WIDTH-1:0] base,
		input logic signed [EXT_WIDTH-1:0] delta
	);
		logic signed [EXT_WIDTH-1:0] sum;
		sum = $signed({{(EXT_WIDTH - DAC_WIDTH){1'b0}}, base}) + delta;
		if (sum < 0) begin
			return '0;
		end else if (sum > DAC_MAX) begin
			return DAC_WIDTH'(DAC_MAX);
		end else begin
			return sum[DAC_WIDTH-1:0];
		end
	endfunction

	always_comb begin
		delta_ext = EXT_WIDTH'(DELTA_MAG);
		pert = sign ? -delta_ext : delta_ext;
		// two extra bits keep the negation of the most negative step exact.
		step_ext = EXT_WIDTH'(ctrl.step);
		step_dir = sign ? -step_ext : step_ext;
	end

	always_ff @(posedge adc_clk or negedge arst_n) begin
		if (!arst_n) begin
			u <= U_INIT;
		end else if (ctrl.update) begin
			u <= sat_add(u, step_dir);
		end
	end

	assign out.u = u;
	assign out.u_plus = sat_add(u, pert);
	assign out.u_minus = sat_add(u, -pert);

endmodule

// ==== spsa_seq.sv ====
module spsa_seq (
	input logic adc_clk,
	input logic arst_n,
	input logic trig_pulse,
	input logic [spsa_pkg::ADC_WIDTH-1:0] adc_in,
	input logic [spsa_pkg::ADC_WIDTH-1:0] gain,
	output spsa_pkg::chan_ctrl_t ctrl,
	output logic advance,
	output spsa_pkg::dac_sel_e dac_sel,
	output logic busy,
	output spsa_pkg::phase_e phase,
	output logic [spsa_pkg::ITER_WIDTH-1:0] iter
);
	import spsa_pkg::*;

	localparam int PROD_WIDTH = 2 * ADC_WIDTH + 2;

	logic [CNT_WIDTH-1:0] cnt;
	logic cnt_done;
	logic [ADC_WIDTH-1:0] jp;
	logic [ADC_WIDTH-1:0] jm;
	logic signed [ADC_WIDTH:0] diff;
	logic signed [PROD_WIDTH-1:0] prod;
	logic signed [PROD_WIDTH-1:0] scaled;
	logic signed [STEP_WIDTH-1:0] step;

	assign cnt_done = (cnt == '0);

	// one down-counter times every phase; it is reloaded on each transition.
	always_ff @(posedge adc_clk or negedge arst_n) begin
		if (!arst_n) begin
			phase <= PH_IDLE;
			cnt <= '0;
			iter <= '0;
		end else begin
			case (phase)
				PH_IDLE: begin
					if (trig_pulse) begin
						phase <= PH_PLUS;
						cnt <= CNT_WIDTH'(DAC_LATENCY_CYCLES - 1);
					end
				end
				PH_PLUS, PH_MINUS: begin
					if (cnt_done) begin
						phase <= (phase == PH_PLUS) ? PH_SAMPLE_P : PH_SAMPLE_M;
						cnt <= CNT_WIDTH'(ADC_LATENCY_CYCLES - 1);
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				PH_SAMPLE_P: begin
					if (cnt_done) begin
						phase <= PH_MINUS;
						cnt <= CNT_WIDTH'(DAC_LATENCY_CYCLES - 1);
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				PH_SAMPLE_M: begin
					if (cnt_done) begin
						phase <= PH_UPDATE;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				PH_UPDATE: begin
					phase <= PH_IDLE;
					iter <= iter + 1'b1;
				end
				default: phase <= PH_IDLE;
			endcase
		end
	end

	// the ADC word is valid on the last cycle of each sample phase.
	always_ff @(posedge adc_clk) begin
		if (phase == PH_SAMPLE_P && cnt_done) begin
			jp <= adc_in;
		end
		if (phase == PH_SAMPLE_M && cnt_done) begin
			jm <= adc_in;
		end
	end

	always_comb begin
		diff = $signed({1'b0, jp}) - $signed({1'b0, jm});
		prod = diff * $signed({1'b0, gain});
		scaled = prod >>> GAIN_SHIFT;
		if (scaled > STEP_MAX) begin
			step = STEP_WIDTH'(STEP_MAX);
		end else if (scaled < STEP_MIN) begin
			step = STEP_WIDTH'(STEP_MIN);
		end else begin
			step = scaled[STEP_WIDTH-1:0];
		end
	end

	always_comb begin
		case (phase)
			PH_PLUS, PH_SAMPLE_P: dac_sel = SEL_PLUS;
			PH_MINUS, PH_SAMPLE_M: dac_sel = SEL_MINUS;
			default: dac_sel = SEL_HOLD;
		endcase
	end

	assign busy = (phase != PH_IDLE);
	assign advance = (phase == PH_UPDATE);
	assign ctrl.update = (phase == PH_UPDATE);
	assign ctrl.step = step; // only taken by the channels while update is high.

endmodule

// ==== dac_out_mux.sv ====
module dac_out_mux (
	input logic adc_clk,
	input logic arst_n,
	input spsa_pkg::dac_sel_e dac_sel,
	input spsa_pkg::chan_out_t [spsa_pkg::N_CHAN-1:0] chan,
	output logic [spsa_pkg::DAC_WIDTH-1:0] dac_a,
	output logic [spsa_pkg::DAC_WIDTH-1:0] dac_b
);
	import spsa_pkg::*;

	logic [N_CHAN-1:0][DAC_WIDTH-1:0] pin_q;

	always_ff @(posedge adc_clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < N_CHAN; i++) begin
				pin_q[i] <= U_INIT;
			end
		end else begin
			for (int i = 0; i < N_CHAN; i++) begin
				case (dac_sel)
					SEL_PLUS: pin_q[i] <= chan[i].u_plus;
					SEL_MINUS: pin_q[i] <= chan[i].u_minus;
					default: pin_q[i] <= chan[i].u;
				endcase
			end
		end
	end

	assign dac_a = pin_q[0];
	assign dac_b = pin_q[1];

endmodule

// ==== spsa_top.sv ====
module spsa_top (
	input logic adc_clk,
	input logic arst_n,
	input logic trig_in,
	input logic [spsa_pkg::ADC_WIDTH-1:0] adc_in,
	input spsa_pkg::wb_req_t wb_req,
	output spsa_pkg::wb_rsp_t wb_rsp,
	output logic [spsa_pkg::DAC_WIDTH-1:0] dac_a,
	output logic [spsa_pkg::DAC_WIDTH-1:0] dac_b
);
	import spsa_pkg::*;

	logic run;
	logic [ADC_WIDTH-1:0] gain;
	logic busy;
	phase_e phase;
	logic [ITER_WIDTH-1:0] iter;
	logic trig_pulse;
	logic advance;
	logic [N_CHAN-1:0] sign;
	chan_ctrl_t ctrl;
	dac_sel_e dac_sel;
	chan_out_t [N_CHAN-1:0] chan_out;
	logic [N_CHAN-1:0][DAC_WIDTH-1:0] u_rb;

	spsa_wb_regs i_regs (
		.adc_clk(adc_clk),
		.arst_n(arst_n),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.run(run),
		.gain(gain),
		.busy(busy),
		.phase(phase),
		.iter(iter),
		.u_rb(u_rb)
	);

	trig_sync i_trig (
		.adc_clk(adc_clk),
		.arst_n(arst_n),
		.trig_in(trig_in),
		.run(run),
		.trig_pulse(trig_pulse)
	);

	perturb_rng i_rng (
		.adc_clk(adc_clk),
		.arst_n(arst_n),
		.advance(advance),
		.sign(sign)
	);

	spsa_seq i_seq (
		.adc_clk(adc_clk),
		.arst_n(arst_n),
		.trig_pulse(trig_pulse),
		.adc_in(adc_in),
		.gain(gain),
		.ctrl(ctrl),
		.advance(advance),
		.dac_sel(dac_sel),
		.busy(busy),
		.phase(phase),
		.iter(iter)
	);

	// both channels share the step and differ only in their perturbation sign.
	for (genvar i = 0; i < N_CHAN; i++) begin : g_chan
		spsa_channel i_chan (
			.adc_clk(adc_clk),
			.arst_n(arst_n),
			.sign(sign[i]),
			.ctrl(ctrl),
			.out(chan_out[i])
		);
		assign u_rb[i] = chan_out[i].u;
	end

	dac_out_mux i_mux (
		.adc_clk(adc_clk),
		.arst_n(arst_n),
		.dac_sel(dac_sel),
		.chan(chan_out),
		.dac_a(dac_a),
		.dac_b(dac_b)
	);

endmodule

// ==== tb_spsa_top.sv ====
module tb_spsa_top;
	import spsa_pkg::*;

	logic adc_clk;
	logic arst_n;
	logic trig_in;
	logic [ADC_WIDTH-1:0] adc_in;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;
	logic [DAC_WIDTH-1:0] dac_a;
	logic [DAC_WIDTH-1:0] dac_b;

	int errors;
	int gain_val;
	int target;
	int offset;
	int u_ref [N_CHAN];
	logic [15:0] lfsr_ref [N_CHAN];

	spsa_top i_dut (
		.adc_clk(adc_clk),
		.arst_n(arst_n),
		.trig_in(trig_in),
		.adc_in(adc_in),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.dac_a(dac_a),
		.dac_b(dac_b)
	);

	initial begin
		adc_clk = 1'b0;
		forever #50 adc_clk = ~adc_clk;
	end

	// the plant response peaks where dac_a meets the target.
	function automatic int plant_out(input int code);
		int level;
		level = offset - ((code > target) ? code - target : target - code);
		return (level < 0) ? 0 : ((level > 4095) ? 4095 : level);
	endfunction

	always @(negedge adc_clk) adc_in = ADC_WIDTH'(plant_out(int'(dac_a)));

	function automatic int sat_code(input int v);
		return (v < 0) ? 0 : ((v > 16383) ? 16383 : v);
	endfunction

	function automatic int step_of(input int jp, input int jm, input int g);
		int s;
		s = ((jp - jm) * g) >>> 4;
		return (s > 32767) ? 32767 : ((s < -32768) ? -32768 : s);
	endfunction

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic check_value(input string what, input int got, input int exp);
		assert (got == exp) else begin
			errors++;
			$display("CHECK FAILED at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout while waiting for %s at time %0t", what, $time);
		$display("errors: %0d", errors);
		$display("FAIL: see errors above");
		$finish;
	endtask

	task automatic wait_for_phase(input phase_e ph, input string what);
		int n;
		n = 0;
		do begin
			@(negedge adc_clk);
			n++;
			if (n > 60) report_timeout(what);
		end while (i_dut.phase != ph);
	endtask

	task automatic pulse_trigger();
		@(negedge adc_clk);
		trig_in = 1'b1;
		repeat (2) @(negedge adc_clk);
		trig_in = 1'b0;
	endtask

	task automatic wb_transfer(input logic we, input logic [WB_ADR_WIDTH-1:0] adr,
			input logic [31:0] wdat, output logic [31:0] rdat);
		int waited;
		waited = 0;
		@(negedge adc_clk);
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
		do begin
			@(negedge adc_clk);
			waited++;
			if (waited > 16) report_timeout("Wishbone ack");
		end while (!wb_rsp.ack);
		check_value("ack latency", waited, 1);
		rdat = wb_rsp.dat;
		@(negedge adc_clk); // ack was taken on the rising edge just before.
		wb_req = '0;
		check_value("ack width", int'(wb_rsp.ack), 0);
	endtask

	task automatic run_iteration(input bit retrigger);
		int pv [N_CHAN];
		int mv [N_CHAN];
		int unew [N_CHAN];
		int dlt;
		int step;
		int start;
		logic [31:0] rd;
		start = int'(i_dut.iter);
		for (int c = 0; c < N_CHAN; c++) begin
			dlt = lfsr_ref[c][0] ? -64 : 64;
			pv[c] = sat_code(u_ref[c] + dlt);
			mv[c] = sat_code(u_ref[c] - dlt);
		end
		step = step_of(plant_out(pv[0]), plant_out(mv[0]), gain_val);
		for (int c = 0; c < N_CHAN; c++) begin
			unew[c] = sat_code(u_ref[c] + (lfsr_ref[c][0] ? -step : step));
		end
		pulse_trigger();
		wait_for_phase(PH_SAMPLE_P, "plus sample phase");
		check_value("dac_a plus", int'(dac_a), pv[0]);
		check_value("dac_b plus", int'(dac_b), pv[1]);
		wb_transfer(1'b0, REG_STATUS, 32'd0, rd);
		check_value("status in plus sample", int'(rd), (int'(PH_SAMPLE_P) << 1) | 1);
		if (retrigger) pulse_trigger(); // lands while busy and must be dropped.
		wait_for_phase(PH_SAMPLE_M, "minus sample phase");
		check_value("dac_a minus", int'(dac_a), mv[0]);
		check_value("dac_b minus", int'(dac_b), mv[1]);
		wait_for_phase(PH_IDLE, "end of iteration");
		check_value("iteration count", int'(i_dut.iter), (start + 1) & 16'hFFFF);
		@(negedge adc_clk);
		check_value("dac_a setpoint", int'(dac_a), unew[0]);
		check_value("dac_b setpoint", int'(dac_b), unew[1]);
		wb_transfer(1'b0, REG_U0, 32'd0, rd);
		check_value("REG_U0", int'(rd), unew[0]);
		wb_transfer(1'b0, REG_U1, 32'd0, rd);
		check_value("REG_U1", int'(rd), unew[1]);
		for (int c = 0; c < N_CHAN; c++) begin
			u_ref[c] = unew[c];
			lfsr_ref[c] = lfsr_next(lfsr_ref[c]);
		end
	endtask

	assert property (@(posedge adc_clk) disable iff (!arst_n)
			wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
		else begin
			errors++;
			$display("CHECK FAILED at time %0t: ack without cyc and stb", $time);
		end

	assert property (@(posedge adc_clk) disable iff (!arst_n) wb_rsp.ack |=> !wb_rsp.ack)
		else begin
			errors++;
			$display("CHECK FAILED at time %0t: ack longer than one cycle", $time);
		end

	initial begin
		logic [31:0] rd;
		int it_before;
		int rail;
		errors = 0;
		void'($urandom(98825));
		arst_n = 1'b0;
		trig_in = 1'b0;
		adc_in = '0;
		wb_req = '0;
		target = 8192;
		offset = 2048;
		gain_val = 0;
		for (int c = 0; c < N_CHAN; c++) begin
			u_ref[c] = 8192;
			lfsr_ref[c] = LFSR_SEED[c];
		end
		repeat (3) @(negedge adc_clk);
		arst_n = 1'b1;
		check_value("dac_a after reset", int'(dac_a), 8192);
		check_value("dac_b after reset", int'(dac_b), 8192);
		wb_transfer(1'b0, REG_STATUS, 32'd0, rd);
		check_value("status after reset", int'(rd), 0);

		wb_transfer(1'b1, REG_CTRL, 32'd1, rd);
		wb_transfer(1'b0, REG_CTRL, 32'd0, rd);
		check_value("REG_CTRL", int'(rd), 1);
		wb_transfer(1'b1, REG_GAIN, 32'd1234, rd);
		wb_transfer(1'b0, REG_GAIN, 32'd0, rd);
		check_value("REG_GAIN", int'(rd), 1234);
		wb_transfer(1'b1, REG_ITER, 32'hBEEF, rd);
		wb_transfer(1'b0, REG_ITER, 32'd0, rd);
		check_value("REG_ITER after write", int'(rd), 0);
		wb_transfer(1'b0, 3'd7, 32'd0, rd);
		check_value("unmapped read", int'(rd), 0);

		for (int i = 0; i < 5; i++) begin
			gain_val = $urandom_range(4095, 1);
			target = $urandom_range(12000, 4000);
			offset = $urandom_range(4095, 1500);
			wb_transfer(1'b1, REG_GAIN, 32'(gain_val), rd);
			run_iteration(i == 4);
		end
		repeat (10) begin
			@(negedge adc_clk);
			check_value("busy after dropped trigger", int'(i_dut.busy), 0);
		end

		// with run clear the trigger never reaches the sequencer.
		wb_transfer(1'b1, REG_CTRL, 32'd0, rd);
		wb_transfer(1'b0, REG_ITER, 32'd0, rd);
		it_before = int'(rd);
		pulse_trigger();
		repeat (15) begin
			@(negedge adc_clk);
			check_value("busy with run clear", int'(i_dut.busy), 0);
		end
		wb_transfer(1'b0, REG_ITER, 32'd0, rd);
		check_value("REG_ITER with run clear", int'(rd), it_before);
		check_value("dac_a with run clear", int'(dac_a), u_ref[0]);
		check_value("dac_b with run clear", int'(dac_b), u_ref[1]);

		wb_transfer(1'b1, REG_CTRL, 32'd1, rd);
		gain_val = 4095;
		offset = 4095;
		// the peak sits on the side of the nearer rail, so the step runs into it.
		target = (u_ref[0] < 8192) ? u_ref[0] - 1000 : u_ref[0] + 1000;
		wb_transfer(1'b1, REG_GAIN, 32'(gain_val), rd);
		run_iteration(1'b0);
		rail = int'(dac_a);
		assert (rail == 0 || rail == 16383) else begin
			errors++;
			$display("CHECK FAILED at time %0t: dac_a %0d is not at a rail", $time, rail);
		end
		target = (rail == 0) ? -100 : 16483; // keeps pushing beyond the rail.
		repeat (2) run_iteration(1'b0);
		check_value("dac_a held at rail", int'(dac_a), rail);

		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// ==== spsa_loop.f ====
spsa_pkg.sv
spsa_wb_regs.sv
trig_sync.sv
perturb_rng.sv
spsa_channel.sv
spsa_seq.sv
dac_out_mux.sv
spsa_top.sv
tb_spsa_top.sv

// ==== Bender.yml ====
package:
  name: spsa_loop

sources:
  - spsa_pkg.sv
  - spsa_wb_regs.sv
  - trig_sync.sv
  - perturb_rng.sv
  - spsa_channel.sv
  - spsa_seq.sv
  - dac_out_mux.sv
  - spsa_top.sv
  - target: test
    files:
      - tb_spsa_top.sv
